/* logic/bus_pkg.sv */
// Bus package for the AXI4-Lite front end and the internal request path
// Holds the address and data widths, the response codes and the
// request and response structs that travel through the register slices
`default_nettype none

package bus_pkg;

	// AXI4-Lite geometry, one 32-bit word per beat
	parameter int ADDR_W = 8;
	parameter int DATA_W = 32;
	parameter int STRB_W = DATA_W / 8;
	parameter int RESP_W = 2;

	typedef logic [RESP_W-1:0] resp_t;

	// Only OKAY and SLVERR are ever returned by this slave
	parameter resp_t RESP_OKAY   = 2'b00;
	parameter resp_t RESP_SLVERR = 2'b10;

	// One accepted transaction on its way to the register bank
	typedef struct packed {
		// High for AW+W, low for AR
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		// All byte lanes enabled, always high for reads
		logic              full_strb;
	} bus_req_t;

	// One response on its way back to the B or R channel
	typedef struct packed {
		// Selects the B channel when high, the R channel when low
		logic              write;
		logic [DATA_W-1:0] rdata;
		resp_t             resp;
	} bus_rsp_t;

endpackage

`default_nettype wire

/* logic/sys_pkg.sv */
// System package describing the register map of the LED and switch controller
// Holds the word offsets, the identification value and the LED control
// struct that the register bank hands to the LED driver
`default_nettype none

package sys_pkg;

	// Number of LEDs and switches on the board
	parameter int LED_W = 4;
	parameter int SW_W  = 4;

	// Width of the blink period register
	parameter int PERIOD_W = 16;

	// Word offsets, the first three are read/write
	parameter logic [bus_pkg::ADDR_W-1:0] REG_LED    = 8'h00;
	parameter logic [bus_pkg::ADDR_W-1:0] REG_BLINK  = 8'h04;
	parameter logic [bus_pkg::ADDR_W-1:0] REG_PERIOD = 8'h08;

	// Read-only offsets, a write here is answered with SLVERR
	parameter logic [bus_pkg::ADDR_W-1:0] REG_SW     = 8'h0C;
	parameter logic [bus_pkg::ADDR_W-1:0] REG_ID     = 8'h10;

	// Value returned by REG_ID, reads as ASCII "MSYS"
	parameter logic [bus_pkg::DATA_W-1:0] SYS_ID = 32'h4d53_5953;

	// LED state driven continuously from the register bank
	typedef struct packed {
		// Level of each LED when not blinking
		logic [LED_W-1:0]    steady;
		// LEDs whose level is inverted during the high blink phase
		logic [LED_W-1:0]    blink_mask;
		// Half period in prescaler ticks minus one, zero stops blinking
		logic [PERIOD_W-1:0] period;
	} led_ctrl_t;

endpackage

`default_nettype wire

/* logic/pipe_slice.sv */
// One-entry valid/ready register slice
// The payload type is a type parameter so the same slice carries
// both bus requests and bus responses
`timescale 1ns/1ps
`default_nettype none

module pipe_slice #(
	parameter type T = logic
) (
	input  wire  clk,
	input  wire  i_rst_n,

	// Upstream side
	input  wire  i_valid,
	input  wire  T i_data,
	output logic o_ready,

	// Downstream side
	output logic o_valid,
	output T     o_data,
	input  wire  i_ready
);

	logic full;

	// A new entry is taken when the slice is empty or its entry leaves
	// in this same cycle
	assign o_ready = !full || i_ready;
	assign o_valid = full;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			full <= 1'b0;
		end else if (o_ready) begin
			full <= i_valid;
		end
	end

	// Payload only moves on an accepted handshake, so it stays stable
	// while the entry waits for downstream ready
	always_ff @(posedge clk) begin
		if (i_valid && o_ready) begin
			o_data <= i_data;
		end
	end

endmodule

`default_nettype wire

/* logic/axil_front.sv */
// AXI4-Lite slave front end
// Turns AW+W and AR handshakes into internal requests with writes winning
// ties, and routes internal responses back onto the B or R channel
`timescale 1ns/1ps
`default_nettype none

module axil_front (
	input  wire                          clk,
	input  wire                          i_rst_n,

	// Write address and data channels
	input  wire                          i_awvalid,
	output logic                         o_awready,
	input  wire  [bus_pkg::ADDR_W-1:0]   i_awaddr,
	input  wire                          i_wvalid,
	output logic                         o_wready,
	input  wire  [bus_pkg::DATA_W-1:0]   i_wdata,
	input  wire  [bus_pkg::STRB_W-1:0]   i_wstrb,

	// Write response channel
	output logic                         o_bvalid,
	input  wire                          i_bready,
	output bus_pkg::resp_t               o_bresp,

	// Read address and data channels
	input  wire                          i_arvalid,
	output logic                         o_arready,
	input  wire  [bus_pkg::ADDR_W-1:0]   i_araddr,
	output logic                         o_rvalid,
	input  wire                          i_rready,
	output logic [bus_pkg::DATA_W-1:0]   o_rdata,
	output bus_pkg::resp_t               o_rresp,

	// Requests towards the register bank
	output logic                         o_req_valid,
	output bus_pkg::bus_req_t            o_req,
	input  wire                          i_req_ready,

	// Responses coming back from the register bank
	input  wire                          i_rsp_valid,
	input  wire  bus_pkg::bus_rsp_t      i_rsp,
	output logic                         o_rsp_ready
);

	import bus_pkg::*;

	logic       wr_fire;
	logic       rd_fire;
	logic       b_fire;
	logic       rsp_fire;
	logic       b_free;
	logic       r_free;
	// Writes accepted whose B handshake has not happened yet
	logic [1:0] wr_outstanding;

	// AW and W are taken together, only when both are present
	assign wr_fire = i_awvalid && i_wvalid && i_req_ready;

	// A read waits while any write is offered or still in flight, so a
	// read never overtakes an earlier write
	assign rd_fire = i_arvalid && !i_awvalid && !i_wvalid &&
		(wr_outstanding == 2'd0) && i_req_ready;

	assign o_awready   = wr_fire;
	assign o_wready    = wr_fire;
	assign o_arready   = rd_fire;
	assign o_req_valid = wr_fire || rd_fire;

	always_comb begin
		o_req.write     = wr_fire;
		o_req.addr      = wr_fire ? i_awaddr : i_araddr;
		o_req.wdata     = i_wdata;
		// Reads carry no strobe and count as full width
		o_req.full_strb = wr_fire ? (&i_wstrb) : 1'b1;
	end

	// A response is popped only when its target channel can take it
	assign b_free      = !o_bvalid || i_bready;
	assign r_free      = !o_rvalid || i_rready;
	assign o_rsp_ready = i_rsp.write ? b_free : r_free;
	assign rsp_fire    = i_rsp_valid && o_rsp_ready;
	assign b_fire      = o_bvalid && i_bready;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_bvalid       <= 1'b0;
			o_rvalid       <= 1'b0;
			wr_outstanding <= '0;
		end else begin
			if (rsp_fire && i_rsp.write) begin
				o_bvalid <= 1'b1;
			end else if (i_bready) begin
				o_bvalid <= 1'b0;
			end
			if (rsp_fire && !i_rsp.write) begin
				o_rvalid <= 1'b1;
			end else if (i_rready) begin
				o_rvalid <= 1'b0;
			end
			// At most three writes fit between the slices and the B register
			if (wr_fire && !b_fire) begin
				wr_outstanding <= wr_outstanding + 2'd1;
			end else if (b_fire && !wr_fire) begin
				wr_outstanding <= wr_outstanding - 2'd1;
			end
		end
	end

	// Channel payloads change only when a new response is loaded
	always_ff @(posedge clk) begin
		if (rsp_fire && i_rsp.write) begin
			o_bresp <= i_rsp.resp;
		end
		if (rsp_fire && !i_rsp.write) begin
			o_rdata <= i_rsp.rdata;
			o_rresp <= i_rsp.resp;
		end
	end

endmodule

`default_nettype wire

/* logic/switch_debounce.sv */
// Switch debouncer
// A two-flop synchronizer per switch followed by a stability counter that
// restarts whenever the sampled value changes
`timescale 1ns/1ps
`default_nettype none

module switch_debounce #(
	parameter int DEBOUNCE_CYCLES = 16
) (
	input  wire                     clk,
	input  wire                     i_rst_n,
	input  wire  [sys_pkg::SW_W-1:0] i_sw,
	output logic [sys_pkg::SW_W-1:0] o_sw
);

	import sys_pkg::*;

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [SW_W-1:0]  sync_1;
	logic [SW_W-1:0]  sync_2;
	// Value that is currently being timed for stability
	logic [SW_W-1:0]  candidate;
	logic [CNT_W-1:0] stable_cnt;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			sync_1     <= '0;
			sync_2     <= '0;
			candidate  <= '0;
			stable_cnt <= '0;
			o_sw       <= '0;
		end else begin
			sync_1 <= i_sw;
			sync_2 <= sync_1;
			if (sync_2 != candidate) begin
				// Any change starts the stability window over
				candidate  <= sync_2;
				stable_cnt <= '0;
			end else if (candidate != o_sw) begin
				if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
					o_sw       <= candidate;
					stable_cnt <= '0;
				end else begin
					stable_cnt <= stable_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/reg_bank.sv */
// Register bank of the LED and switch controller
// Decodes one request per cycle, holds the LED, blink and period registers,
// answers reads of every register and flags bad accesses with SLVERR
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
	input  wire                      clk,
	input  wire                      i_rst_n,

	// Requests from the request slice
	input  wire                      i_req_valid,
	input  wire  bus_pkg::bus_req_t  i_req,
	output logic                     o_req_ready,

	// Responses into the response slice
	output logic                     o_rsp_valid,
	output bus_pkg::bus_rsp_t        o_rsp,
	input  wire                      i_rsp_ready,

	// Debounced switches and LED state
	input  wire  [sys_pkg::SW_W-1:0] i_sw,
	output sys_pkg::led_ctrl_t       o_led_ctrl
);

	import bus_pkg::*;
	import sys_pkg::*;

	logic [LED_W-1:0]    led_q;
	logic [LED_W-1:0]    blink_q;
	logic [PERIOD_W-1:0] period_q;
	logic                take;
	logic                wr_ok;
	logic                we_led;
	logic                we_blink;
	logic                we_period;

	// A request is consumed only when its response has somewhere to go
	assign o_req_ready = i_rsp_ready;
	assign o_rsp_valid = i_req_valid;
	assign take        = i_req_valid && i_rsp_ready;

	// Partial strobe writes are refused and leave the registers alone
	assign wr_ok = i_req.write && i_req.full_strb;

	always_comb begin
		o_rsp.write = i_req.write;
		o_rsp.rdata = '0;
		o_rsp.resp  = RESP_OKAY;
		we_led      = 1'b0;
		we_blink    = 1'b0;
		we_period   = 1'b0;
		case (i_req.addr)
			REG_LED: begin
				o_rsp.rdata[LED_W-1:0] = led_q;
				we_led = wr_ok;
			end
			REG_BLINK: begin
				o_rsp.rdata[LED_W-1:0] = blink_q;
				we_blink = wr_ok;
			end
			REG_PERIOD: begin
				o_rsp.rdata[PERIOD_W-1:0] = period_q;
				we_period = wr_ok;
			end
			REG_SW: o_rsp.rdata[SW_W-1:0] = i_sw;
			REG_ID: o_rsp.rdata = SYS_ID;
			default: o_rsp.resp = RESP_SLVERR;
		endcase
		// Writes to read-only registers and partial strobes both fail here
		if (i_req.write && !(we_led || we_blink || we_period)) begin
			o_rsp.resp = RESP_SLVERR;
		end
		// Write responses carry no data
		if (i_req.write) begin
			o_rsp.rdata = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			led_q    <= '0;
			blink_q  <= '0;
			period_q <= '0;
		end else if (take) begin
			if (we_led) begin
				led_q <= i_req.wdata[LED_W-1:0];
			end
			if (we_blink) begin
				blink_q <= i_req.wdata[LED_W-1:0];
			end
			if (we_period) begin
				period_q <= i_req.wdata[PERIOD_W-1:0];
			end
		end
	end

	assign o_led_ctrl.steady     = led_q;
	assign o_led_ctrl.blink_mask = blink_q;
	assign o_led_ctrl.period     = period_q;

endmodule

`default_nettype wire

/* logic/led_driver.sv */
// LED driver with a prescaled blink timer
// Inverts the masked steady bits while the blink phase is high
`timescale 1ns/1ps
`default_nettype none

module led_driver #(
	parameter int PRESCALE = 1000
) (
	input  wire                       clk,
	input  wire                       i_rst_n,
	input  wire  sys_pkg::led_ctrl_t  i_led_ctrl,
	output logic [sys_pkg::LED_W-1:0] o_led
);

	import sys_pkg::*;

	localparam int PRE_W = $clog2(PRESCALE + 1);

	logic [PRE_W-1:0]    pre_cnt;
	logic [PERIOD_W-1:0] period_cnt;
	logic                tick;
	logic                phase;

	// One tick every PRESCALE clock cycles
	assign tick = (pre_cnt == PRE_W'(PRESCALE - 1));

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			pre_cnt    <= '0;
			period_cnt <= '0;
			phase      <= 1'b0;
		end else if (i_led_ctrl.period == '0) begin
			// Blinking is off, restart cleanly when a period is written
			pre_cnt    <= '0;
			period_cnt <= '0;
			phase      <= 1'b0;
		end else begin
			pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
			if (tick) begin
				// Compare with >= so a shorter new period takes effect at once
				if (period_cnt >= i_led_ctrl.period) begin
					period_cnt <= '0;
					phase      <= ~phase;
				end else begin
					period_cnt <= period_cnt + 1'b1;
				end
			end
		end
	end

	assign o_led = i_led_ctrl.steady ^ (i_led_ctrl.blink_mask & {LED_W{phase}});

endmodule

`default_nettype wire

/* logic/mini_sys.sv */
// Top level of the LED and switch controller
// Connects the AXI4-Lite front end, the request and response slices,
// the register bank, the switch debouncer and the LED driver
`timescale 1ns/1ps
`default_nettype none

module mini_sys #(
	parameter int DEBOUNCE_CYCLES = 16,
	parameter int PRESCALE        = 1000
) (
	input  wire                         clk,
	input  wire                         i_rst_n,
	input  wire                         i_awvalid,
	output logic                        o_awready,
	input  wire  [bus_pkg::ADDR_W-1:0]  i_awaddr,
	input  wire                         i_wvalid,
	output logic                        o_wready,
	input  wire  [bus_pkg::DATA_W-1:0]  i_wdata,
	input  wire  [bus_pkg::STRB_W-1:0]  i_wstrb,
	output logic                        o_bvalid,
	input  wire                         i_bready,
	output bus_pkg::resp_t              o_bresp,
	input  wire                         i_arvalid,
	output logic                        o_arready,
	input  wire  [bus_pkg::ADDR_W-1:0]  i_araddr,
	output logic                        o_rvalid,
	input  wire                         i_rready,
	output logic [bus_pkg::DATA_W-1:0]  o_rdata,
	output bus_pkg::resp_t              o_rresp,
	input  wire  [sys_pkg::SW_W-1:0]    i_sw,
	output logic [sys_pkg::LED_W-1:0]   o_led
);

	import bus_pkg::*;
	import sys_pkg::*;

	// Front end to request slice, and request slice to register bank
	logic      front_req_valid;
	logic      front_req_ready;
	bus_req_t  front_req;
	logic      bank_req_valid;
	logic      bank_req_ready;
	bus_req_t  bank_req;

	// Register bank to response slice, and response slice to front end
	logic      bank_rsp_valid;
	logic      bank_rsp_ready;
	bus_rsp_t  bank_rsp;
	logic      front_rsp_valid;
	logic      front_rsp_ready;
	bus_rsp_t  front_rsp;

	logic [SW_W-1:0] sw_stable;
	led_ctrl_t       led_ctrl;

	axil_front front_i (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
		.i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
		.o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
		.i_arvalid(i_arvalid), .o_arready(o_arready), .i_araddr(i_araddr),
		.o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
		.o_req_valid(front_req_valid), .o_req(front_req), .i_req_ready(front_req_ready),
		.i_rsp_valid(front_rsp_valid), .i_rsp(front_rsp), .o_rsp_ready(front_rsp_ready)
	);

	pipe_slice #(.T(bus_req_t)) req_slice (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_valid(front_req_valid), .i_data(front_req), .o_ready(front_req_ready),
		.o_valid(bank_req_valid), .o_data(bank_req), .i_ready(bank_req_ready)
	);

	reg_bank bank_i (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_req_valid(bank_req_valid), .i_req(bank_req), .o_req_ready(bank_req_ready),
		.o_rsp_valid(bank_rsp_valid), .o_rsp(bank_rsp), .i_rsp_ready(bank_rsp_ready),
		.i_sw(sw_stable), .o_led_ctrl(led_ctrl)
	);

	pipe_slice #(.T(bus_rsp_t)) rsp_slice (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_valid(bank_rsp_valid), .i_data(bank_rsp), .o_ready(bank_rsp_ready),
		.o_valid(front_rsp_valid), .o_data(front_rsp), .i_ready(front_rsp_ready)
	);

	switch_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) debounce_i (
		.clk(clk), .i_rst_n(i_rst_n), .i_sw(i_sw), .o_sw(sw_stable)
	);

	led_driver #(.PRESCALE(PRESCALE)) led_i (
		.clk(clk), .i_rst_n(i_rst_n), .i_led_ctrl(led_ctrl), .o_led(o_led)
	);

endmodule

`default_nettype wire

/* verification/mini_sys_asserts.sv */
// Handshake assertions bound into the AXI4-Lite front end
// B, R and internal response valids hold with a stable payload until ready,
// and no valid leaves the front end while reset is applied
`timescale 1ns/1ps
`default_nettype none

module mini_sys_asserts (
	input wire                        clk,
	input wire                        i_rst_n,
	input wire                        o_bvalid,
	input wire                        i_bready,
	input wire bus_pkg::resp_t        o_bresp,
	input wire                        o_rvalid,
	input wire                        i_rready,
	input wire [bus_pkg::DATA_W-1:0]  o_rdata,
	input wire bus_pkg::resp_t        o_rresp,
	input wire                        i_rsp_valid,
	input wire                        o_rsp_ready,
	input wire bus_pkg::bus_rsp_t     i_rsp,
	input wire                        o_req_valid
);

	// Counts failed assertions so the testbench can judge the run
	int fail_count = 0;

	assert property (@(posedge clk) disable iff (!i_rst_n)
		o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp))
	else begin
		$error("bvalid dropped or bresp changed before bready");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!i_rst_n)
		o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp))
	else begin
		$error("rvalid dropped or R payload changed before rready");
		fail_count++;
	end

	// The response slice must keep its entry until the front end pops it
	assert property (@(posedge clk) disable iff (!i_rst_n)
		i_rsp_valid && !o_rsp_ready |=> i_rsp_valid && $stable(i_rsp))
	else begin
		$error("response entry dropped or changed before it was taken");
		fail_count++;
	end

	assert property (@(posedge clk) !i_rst_n |=> !o_bvalid && !o_rvalid)
	else begin
		$error("bvalid or rvalid high during reset");
		fail_count++;
	end

	assert property (@(posedge clk) !i_rst_n |-> !o_req_valid)
	else begin
		$error("request issued during reset");
		fail_count++;
	end

endmodule

`default_nettype wire

/* verification/mini_sys_tb.sv */
// Testbench for the LED and switch controller
// Holds the clock and reset, AXI4-Lite host tasks, an LCG for write data
// and the directed tests for reset, registers, errors, switches and blinking
`timescale 1ns/1ps
`default_nettype none

module mini_sys_tb;

	import bus_pkg::*;
	import sys_pkg::*;

	localparam int CLK_PERIOD      = 20;
	localparam int RESET_CYCLES    = 10;
	localparam int WAIT_LIMIT      = 100;
	localparam int DEBOUNCE_CYCLES = 4;
	localparam int PRESCALE        = 2;
	// Length of one blink phase with a period register of 1
	localparam int BLINK_CYCLES    = PRESCALE * (1 + 1);
	localparam logic [31:0] LCG_SEED    = 32'h46ad_336a;
	localparam logic [31:0] LED_MASK    = 32'h0000_000f;
	localparam logic [31:0] PERIOD_MASK = 32'h0000_ffff;
	localparam logic [ADDR_W-1:0] UNMAPPED_ADDR = 8'h14;

	logic              clk;
	logic              i_rst_n;
	logic              i_awvalid;
	logic              o_awready;
	logic [ADDR_W-1:0] i_awaddr;
	logic              i_wvalid;
	logic              o_wready;
	logic [DATA_W-1:0] i_wdata;
	logic [STRB_W-1:0] i_wstrb;
	logic              o_bvalid;
	logic              i_bready;
	resp_t             o_bresp;
	logic              i_arvalid;
	logic              o_arready;
	logic [ADDR_W-1:0] i_araddr;
	logic              o_rvalid;
	logic              i_rready;
	logic [DATA_W-1:0] o_rdata;
	resp_t             o_rresp;
	logic [SW_W-1:0]   i_sw;
	logic [LED_W-1:0]  o_led;

	// Shadow copies of the read/write registers as the host expects them
	logic [31:0] exp_led;
	logic [31:0] exp_blink;
	logic [31:0] exp_period;
	logic [31:0] lcg_state;
	string       cur_test;

	mini_sys #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES), .PRESCALE(PRESCALE)) dut_i (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
		.i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
		.o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
		.i_arvalid(i_arvalid), .o_arready(o_arready), .i_araddr(i_araddr),
		.o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
		.i_sw(i_sw), .o_led(o_led)
	);

	// Handshake checks live inside the front end
	bind axil_front mini_sys_asserts asserts_i (
		.clk(clk), .i_rst_n(i_rst_n),
		.o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
		.o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
		.i_rsp_valid(i_rsp_valid), .o_rsp_ready(o_rsp_ready), .i_rsp(i_rsp),
		.o_req_valid(o_req_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Numerical Recipes constants, full 32-bit state
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("ERROR in %s: timed out waiting for %s", cur_test, what);
		abort_run();
	endtask

	task automatic expect_equal(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			$display("CHECK FAILED %s: %s expected %0h actual %0h", cur_test, what, exp, act);
			abort_run();
		end
	endtask

	// Moves to the middle of the low clock phase where every output is stable
	task automatic settle();
		#(CLK_PERIOD / 4);
	endtask

	// Offers AW and W together and returns at the falling edge after acceptance
	task automatic send_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
			input logic [STRB_W-1:0] strb);
		int waited;
		waited = 0;
		i_awvalid = 1'b1;
		i_awaddr  = addr;
		i_wvalid  = 1'b1;
		i_wdata   = data;
		i_wstrb   = strb;
		settle();
		while (!(o_awready && o_wready)) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("awready and wready");
			end
			@(negedge clk);
			settle();
		end
		@(negedge clk);
		i_awvalid = 1'b0;
		i_wvalid  = 1'b0;
	endtask

	// Waits for bvalid, then lets the B handshake happen with bready high
	task automatic take_b(output resp_t resp);
		int waited;
		waited = 0;
		while (!o_bvalid) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("bvalid");
			end
			@(negedge clk);
		end
		resp = o_bresp;
		@(negedge clk);
	endtask

	task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
			input logic [STRB_W-1:0] strb, output resp_t resp);
		send_write(addr, data, strb);
		take_b(resp);
	endtask

	task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
			output resp_t resp);
		int waited;
		waited = 0;
		i_arvalid = 1'b1;
		i_araddr  = addr;
		settle();
		while (!o_arready) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("arready");
			end
			@(negedge clk);
			settle();
		end
		@(negedge clk);
		i_arvalid = 1'b0;
		waited = 0;
		while (!o_rvalid) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("rvalid");
			end
			@(negedge clk);
		end
		data = o_rdata;
		resp = o_rresp;
		@(negedge clk);
	endtask

	// Reads the three read/write registers and compares them with the shadows
	task automatic verify_registers();
		logic [31:0] data;
		resp_t       resp;
		axil_read(REG_LED, data, resp);
		expect_equal("REG_LED resp", RESP_OKAY, resp);
		expect_equal("REG_LED data", exp_led, data);
		axil_read(REG_BLINK, data, resp);
		expect_equal("REG_BLINK resp", RESP_OKAY, resp);
		expect_equal("REG_BLINK data", exp_blink, data);
		axil_read(REG_PERIOD, data, resp);
		expect_equal("REG_PERIOD resp", RESP_OKAY, resp);
		expect_equal("REG_PERIOD data", exp_period, data);
	endtask

	task automatic reset_state();
		logic [31:0] data;
		resp_t       resp;
		cur_test = "reset_state";
		expect_equal("o_led", 0, o_led);
		expect_equal("awready", 0, o_awready);
		expect_equal("wready", 0, o_wready);
		expect_equal("arready", 0, o_arready);
		expect_equal("bvalid", 0, o_bvalid);
		expect_equal("rvalid", 0, o_rvalid);
		verify_registers();
		axil_read(REG_ID, data, resp);
		expect_equal("REG_ID resp", RESP_OKAY, resp);
		expect_equal("REG_ID data", SYS_ID, data);
	endtask

	task automatic register_readback();
		logic [31:0] data;
		resp_t       resp;
		cur_test = "register_readback";
		data = lcg_next();
		axil_write(REG_LED, data, 4'hf, resp);
		expect_equal("REG_LED write resp", RESP_OKAY, resp);
		exp_led = data & LED_MASK;
		data = lcg_next();
		axil_write(REG_BLINK, data, 4'hf, resp);
		expect_equal("REG_BLINK write resp", RESP_OKAY, resp);
		exp_blink = data & LED_MASK;
		data = lcg_next();
		axil_write(REG_PERIOD, data, 4'hf, resp);
		expect_equal("REG_PERIOD write resp", RESP_OKAY, resp);
		exp_period = data & PERIOD_MASK;
		verify_registers();
		// A zero period stops blinking so the LEDs show the steady bits
		axil_write(REG_PERIOD, 32'h0, 4'hf, resp);
		expect_equal("REG_PERIOD clear resp", RESP_OKAY, resp);
		exp_period = 32'h0;
		expect_equal("o_led with blink off", exp_led, o_led);
	endtask

	task automatic error_responses();
		logic [31:0] data;
		resp_t       resp;
		cur_test = "error_responses";
		axil_write(REG_SW, lcg_next(), 4'hf, resp);
		expect_equal("write REG_SW resp", RESP_SLVERR, resp);
		axil_write(REG_ID, lcg_next(), 4'hf, resp);
		expect_equal("write REG_ID resp", RESP_SLVERR, resp);
		axil_read(UNMAPPED_ADDR, data, resp);
		expect_equal("unmapped read resp", RESP_SLVERR, resp);
		axil_write(REG_LED, lcg_next(), 4'b0011, resp);
		expect_equal("partial strobe LED resp", RESP_SLVERR, resp);
		axil_write(REG_PERIOD, lcg_next(), 4'b1110, resp);
		expect_equal("partial strobe PERIOD resp", RESP_SLVERR, resp);
		verify_registers();
	endtask

	task automatic switch_path();
		logic [31:0] data;
		resp_t       resp;
		int          polls;
		cur_test = "switch_path";
		i_sw  = 4'b1010;
		polls = 0;
		axil_read(REG_SW, data, resp);
		expect_equal("REG_SW resp", RESP_OKAY, resp);
		while (data != 32'ha) begin
			polls++;
			if (polls > 20) begin
				report_timeout("the switch pattern in REG_SW");
			end
			axil_read(REG_SW, data, resp);
			expect_equal("REG_SW resp", RESP_OKAY, resp);
		end
		// Two cycles of the opposite pattern, shorter than the debounce window
		i_sw = 4'b0101;
		@(negedge clk);
		@(negedge clk);
		i_sw = 4'b1010;
		repeat (4) begin
			axil_read(REG_SW, data, resp);
			expect_equal("REG_SW resp after glitch", RESP_OKAY, resp);
			expect_equal("REG_SW after glitch", 32'ha, data);
		end
	endtask

	task automatic blink_pattern();
		resp_t      resp;
		logic [3:0] mask;
		logic [3:0] prev;
		int         changes;
		int         waited;
		int         since;
		cur_test = "blink_pattern";
		mask = 4'b0101;
		axil_write(REG_BLINK, 32'h5, 4'hf, resp);
		expect_equal("REG_BLINK write resp", RESP_OKAY, resp);
		exp_blink = 32'h5;
		axil_write(REG_LED, 32'h3, 4'hf, resp);
		expect_equal("REG_LED write resp", RESP_OKAY, resp);
		exp_led = 32'h3;
		axil_write(REG_PERIOD, 32'h1, 4'hf, resp);
		expect_equal("REG_PERIOD write resp", RESP_OKAY, resp);
		exp_period = 32'h1;
		// Blinking was off until the period write, so the phase starts low
		prev = o_led;
		expect_equal("LED at blink start", 4'b0011, prev);
		changes = 0;
		waited  = 0;
		since   = 0;
		while (changes < 4) begin
			@(negedge clk);
			waited++;
			since++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("four blink phase changes");
			end
			expect_equal("unmasked LED bits", 4'b0011 & ~mask, o_led & ~mask);
			if (o_led != prev) begin
				// Each phase change flips exactly the masked bits
				expect_equal("LED after phase change", prev ^ mask, o_led);
				// Every full phase lasts PRESCALE ticks per period step
				if (changes > 0) begin
					expect_equal("cycles between phase changes", BLINK_CYCLES, since);
				end
				changes++;
				prev  = o_led;
				since = 0;
			end
		end
		axil_write(REG_PERIOD, 32'h0, 4'hf, resp);
		expect_equal("REG_PERIOD clear resp", RESP_OKAY, resp);
		exp_period = 32'h0;
	endtask

	task automatic back_pressure();
		logic [31:0] data;
		logic [31:0] rdata;
		resp_t       resp;
		int          waited;
		cur_test = "back_pressure";
		data = lcg_next();
		i_bready = 1'b0;
		send_write(REG_LED, data, 4'hf);
		exp_led = data & LED_MASK;
		i_arvalid = 1'b1;
		i_araddr  = REG_LED;
		waited = 0;
		settle();
		while (!o_bvalid) begin
			expect_equal("arready while B pending", 0, o_arready);
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("bvalid with bready low");
			end
			@(negedge clk);
			settle();
		end
		// Hold B off a little longer, the read must keep waiting
		repeat (4) begin
			expect_equal("arready while B pending", 0, o_arready);
			expect_equal("bvalid held", 1, o_bvalid);
			@(negedge clk);
			settle();
		end
		expect_equal("bresp", RESP_OKAY, o_bresp);
		@(negedge clk);
		i_bready = 1'b1;
		settle();
		expect_equal("arready before B handshake", 0, o_arready);
		@(negedge clk);
		expect_equal("bvalid after B handshake", 0, o_bvalid);
		waited = 0;
		settle();
		while (!o_arready) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("arready after B");
			end
			@(negedge clk);
			settle();
		end
		@(negedge clk);
		i_arvalid = 1'b0;
		waited = 0;
		while (!o_rvalid) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("rvalid after B");
			end
			@(negedge clk);
		end
		rdata = o_rdata;
		resp  = o_rresp;
		@(negedge clk);
		expect_equal("read resp", RESP_OKAY, resp);
		expect_equal("read data", exp_led, rdata);
	endtask

	initial begin
		i_rst_n    = 1'b0;
		i_awvalid  = 1'b0;
		i_awaddr   = '0;
		i_wvalid   = 1'b0;
		i_wdata    = '0;
		i_wstrb    = '0;
		i_bready   = 1'b1;
		i_arvalid  = 1'b0;
		i_araddr   = '0;
		i_rready   = 1'b1;
		i_sw       = '0;
		lcg_state  = LCG_SEED;
		exp_led    = 32'h0;
		exp_blink  = 32'h0;
		exp_period = 32'h0;
		cur_test   = "reset";
		repeat (RESET_CYCLES) @(negedge clk);
		i_rst_n = 1'b1;
		@(negedge clk);
		reset_state();
		register_readback();
		error_responses();
		switch_path();
		blink_pattern();
		back_pressure();
		if (dut_i.front_i.asserts_i.fail_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("ERROR: %0d handshake assertion failures",
				dut_i.front_i.asserts_i.fail_count);
			abort_run();
		end
	end

endmodule

`default_nettype wire

/* project.f */
logic/bus_pkg.sv
logic/sys_pkg.sv
logic/pipe_slice.sv
logic/axil_front.sv
logic/switch_debounce.sv
logic/reg_bank.sv
logic/led_driver.sv
logic/mini_sys.sv
verification/mini_sys_asserts.sv
verification/mini_sys_tb.sv
